//--- logic/spuAudioPkg.sv
package spuAudioPkg;

	// width of one audio word.
	localparam int SAMPLE_W = 16;

	// volume 0x7fff is unity, so products come back down by 15 bits.
	localparam int VOL_SHIFT = 15;

	localparam int NOISE_CFG_W = 4;	// shift and step fields.

	// signed pcm sample.
	typedef logic signed [SAMPLE_W-1:0] audioSample_t;

	// signed channel volume.
	typedef logic signed [SAMPLE_W-1:0] volume_t;

	// selects the one-hot offset the noise timer adds on overflow.
	typedef logic [NOISE_CFG_W-1:0] noiseShift_t;

	// signed timer increment, sign extended inside the noise unit.
	typedef logic [NOISE_CFG_W-1:0] noiseStep_t;

	// one stereo output frame.
	// left sits in the upper word.
	typedef struct packed {
		audioSample_t left;
		audioSample_t right;
	} stereoFrame_t;

endpackage

//--- logic/spuBusPkg.sv
package spuBusPkg;

	localparam int REG_DATA_W = 16;	// register write data.

	typedef logic [REG_DATA_W-1:0] regData_t;

	// register map of the noise voice.
	typedef enum logic [1:0] {
		REG_CTRL = 2'd0,
		REG_VOL_L = 2'd1,
		REG_VOL_R = 2'd2
	} regAddr_t;

	// one write beat from software.
	typedef struct packed {
		logic valid;
		regAddr_t addr;
		regData_t data;
	} regWrite_t;

	// layout of a REG_CTRL write, taken from data bits 8:0.
	typedef struct packed {
		logic enable;	// bit 8.
		spuAudioPkg::noiseShift_t shift;	// bits 7:4.
		spuAudioPkg::noiseStep_t step;	// bits 3:0.
	} noiseCtrl_t;

endpackage

//--- logic/spuRegisterBank.sv
`timescale 1ns/10ps

module spuRegisterBank (
	input logic clk,
	input logic i_nrst,
	input spuBusPkg::regWrite_t i_regWr,
	output spuBusPkg::noiseCtrl_t o_ctrl,
	output spuAudioPkg::volume_t o_volLeft,
	output spuAudioPkg::volume_t o_volRight
);

	localparam int CTRL_W = $bits(spuBusPkg::noiseCtrl_t);

	spuBusPkg::noiseCtrl_t ctrlReg;
	spuAudioPkg::volume_t volLeftReg;
	spuAudioPkg::volume_t volRightReg;

	// write decode.
	// upper control data bits are don't care.
	always_ff @(posedge clk) begin
		if (!i_nrst) begin
			ctrlReg <= '0;	// voice off, shift and step zero.
			volLeftReg <= '0;
			volRightReg <= '0;
		end else if (i_regWr.valid) begin
			case (i_regWr.addr)
				spuBusPkg::REG_CTRL: begin
					ctrlReg <= spuBusPkg::noiseCtrl_t'(i_regWr.data[CTRL_W-1:0]);
				end
				spuBusPkg::REG_VOL_L: begin
					volLeftReg <= i_regWr.data;
				end
				spuBusPkg::REG_VOL_R: begin
					volRightReg <= i_regWr.data;
				end
				default: begin
					volLeftReg <= volLeftReg;	// undefined address, nothing changes.
				end
			endcase
		end
	end

	// the datapath picks these up on its next sample tick.
	assign o_ctrl = ctrlReg;
	assign o_volLeft = volLeftReg;
	assign o_volRight = volRightReg;

	// software only ever targets the three defined registers.
	assert property (@(posedge clk) disable iff (!i_nrst)
		i_regWr.valid |-> i_regWr.addr inside
			{spuBusPkg::REG_CTRL, spuBusPkg::REG_VOL_L, spuBusPkg::REG_VOL_R})
		else $error("spuRegisterBank: write to undefined address %0h", i_regWr.addr);

endmodule

//--- logic/sampleTickGen.sv
`timescale 1ns/10ps

module sampleTickGen #(
	parameter int CLKS_PER_SAMPLE = 768
) (
	input logic clk,
	input logic i_nrst,
	output logic o_tick
);

	localparam int CNT_W = (CLKS_PER_SAMPLE > 1) ? $clog2(CLKS_PER_SAMPLE) : 1;
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLKS_PER_SAMPLE - 1);

	logic [CNT_W-1:0] count;
	logic expired;

	assign expired = (count == '0);

	// down-counter, tick registered one cycle after expiry.
	always_ff @(posedge clk) begin
		if (!i_nrst) begin
			count <= RELOAD;
			o_tick <= 1'b0;
		end else begin
			count <= expired ? RELOAD : count - 1'b1;
			o_tick <= expired;
		end
	end

	// ticks stay isolated single pulses.
	if (CLKS_PER_SAMPLE > 1) begin : gTickSpacing
		assert property (@(posedge clk) disable iff (!i_nrst)
			o_tick |=> !o_tick)
			else $error("sampleTickGen: adjacent ticks");
	end

endmodule

//--- logic/noiseUnit.sv
`timescale 1ns/10ps

module noiseUnit (
	input logic clk,
	input logic i_nrst,
	input logic i_tick,
	input spuAudioPkg::noiseShift_t i_noiseShift,
	input spuAudioPkg::noiseStep_t i_noiseStep,
	output spuAudioPkg::audioSample_t o_noiseOut
);

	localparam int TIMER_W = 19;
	localparam int LEVEL_W = $bits(spuAudioPkg::audioSample_t);
	localparam int STEP_W = $bits(spuAudioPkg::noiseStep_t);

	logic [TIMER_W-1:0] noiseTimer;
	logic [LEVEL_W-1:0] noiseLevel;

	logic parityBit;
	logic [LEVEL_W-1:0] nextLevel;
	logic [TIMER_W-1:0] stepExt;
	logic [TIMER_W-1:0] steppedTimer;
	logic [LEVEL_W-1:0] shiftAdd;
	logic [TIMER_W-1:0] onceTimer;
	logic [TIMER_W-1:0] twiceTimer;
	logic [TIMER_W-1:0] nextTimer;

	// inverted parity of taps 15, 12, 11 and 10.
	assign parityBit = ~(noiseLevel[15] ^ noiseLevel[12] ^ noiseLevel[11] ^ noiseLevel[10]);
	assign nextLevel = {noiseLevel[LEVEL_W-2:0], parityBit};	// parity enters at bit 0.

	assign stepExt = {{(TIMER_W-STEP_W){i_noiseStep[STEP_W-1]}}, i_noiseStep};
	assign steppedTimer = noiseTimer + stepExt;

	// one-hot offset, shift 0 picks bit 15 and shift 15 picks bit 0.
	assign shiftAdd = {1'b1, {(LEVEL_W-1){1'b0}}} >> i_noiseShift;

	assign onceTimer = steppedTimer + {1'b0, shiftAdd, 2'b00};
	assign twiceTimer = steppedTimer + {shiftAdd, 3'b000};	// double offset.

	// overflow correction, a second offset when one is not enough.
	always_comb begin
		nextTimer = steppedTimer;
		if (steppedTimer[TIMER_W-1]) begin
			nextTimer = onceTimer[TIMER_W-1] ? twiceTimer : onceTimer;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_nrst) begin
			noiseTimer <= '0;
			noiseLevel <= '0;
		end else if (i_tick) begin
			noiseTimer <= nextTimer;
			noiseLevel <= nextLevel;
		end
	end

	// sample for this tick, loaded into the register at the same edge.
	assign o_noiseOut = nextLevel;

	// all ones feeds back a one forever.
	assert property (@(posedge clk) disable iff (!i_nrst)
		noiseLevel != {LEVEL_W{1'b1}})
		else $error("noiseUnit: shift register locked at %h", noiseLevel);

endmodule

//--- logic/noiseVolumeStage.sv
`timescale 1ns/10ps

module noiseVolumeStage #(
	parameter int MAX_CREDITS = 4
) (
	input logic clk,
	input logic i_nrst,
	input logic i_tick,
	input logic i_enable,
	input spuAudioPkg::audioSample_t i_noise,
	input spuAudioPkg::volume_t i_volLeft,
	input spuAudioPkg::volume_t i_volRight,
	input logic i_creditReturn,
	output spuAudioPkg::stereoFrame_t o_frame,
	output logic o_frameValid,
	output logic o_overrun
);

	localparam int SAMPLE_W = $bits(spuAudioPkg::audioSample_t);
	localparam int PROD_W = 2 * SAMPLE_W;
	localparam int CREDIT_W = $clog2(MAX_CREDITS + 1);

	logic signed [PROD_W-1:0] prodLeft;
	logic signed [PROD_W-1:0] prodRight;
	spuAudioPkg::stereoFrame_t nextFrame;
	spuAudioPkg::stereoFrame_t frameReg;

	logic pending;
	logic overrun;
	logic frameValid;
	logic [CREDIT_W-1:0] credits;

	// signed scale, q15 volume.
	assign prodLeft = i_noise * i_volLeft;
	assign prodRight = i_noise * i_volRight;

	// taking bits 30:15 is the floor shift by 15.
	assign nextFrame.left = i_enable ? prodLeft[spuAudioPkg::VOL_SHIFT +: SAMPLE_W] : '0;
	assign nextFrame.right = i_enable ? prodRight[spuAudioPkg::VOL_SHIFT +: SAMPLE_W] : '0;

	// a newer frame overwrites a stalled one.
	always_ff @(posedge clk) begin
		if (i_tick) begin
			frameReg <= nextFrame;
		end
	end

	assign frameValid = pending && (credits != '0);

	always_ff @(posedge clk) begin
		if (!i_nrst) begin
			pending <= 1'b0;
			overrun <= 1'b0;
			credits <= CREDIT_W'(MAX_CREDITS);
		end else begin
			if (i_tick) begin
				pending <= 1'b1;
			end else if (frameValid) begin
				pending <= 1'b0;
			end
			// sticky until reset.
			if (i_tick && pending && !frameValid) begin
				overrun <= 1'b1;
			end
			credits <= credits + CREDIT_W'(i_creditReturn) - CREDIT_W'(frameValid);
		end
	end

	assign o_frame = frameReg;
	assign o_frameValid = frameValid;
	assign o_overrun = overrun;

	// the sink never returns more than it was given.
	assert property (@(posedge clk) disable iff (!i_nrst)
		credits <= MAX_CREDITS)
		else $error("noiseVolumeStage: credits %0h above limit", credits);

	// an empty credit counter stays empty until a return.
	assert property (@(posedge clk) disable iff (!i_nrst)
		(credits == '0 && !i_creditReturn) |=> !o_frameValid)
		else $error("noiseVolumeStage: frame sent without credit");

endmodule

//--- logic/spuNoiseTop.sv
`timescale 1ns/10ps

module spuNoiseTop #(
	parameter int CLKS_PER_SAMPLE = 768,
	parameter int MAX_CREDITS = 4
) (
	input logic clk,
	input logic i_nrst,
	input spuBusPkg::regWrite_t i_regWr,
	input logic i_creditReturn,
	output spuAudioPkg::stereoFrame_t o_frame,
	output logic o_frameValid,
	output logic o_overrun
);

	logic tick;
	spuAudioPkg::audioSample_t noise;
	spuBusPkg::noiseCtrl_t ctrl;
	spuAudioPkg::volume_t volLeft;
	spuAudioPkg::volume_t volRight;

	spuRegisterBank i_regBank (
		.clk(clk),
		.i_nrst(i_nrst),
		.i_regWr(i_regWr),
		.o_ctrl(ctrl),
		.o_volLeft(volLeft),
		.o_volRight(volRight)
	);

	// 44.1 kHz sample strobe.
	sampleTickGen #(
		.CLKS_PER_SAMPLE(CLKS_PER_SAMPLE)
	) i_tickGen (
		.clk(clk),
		.i_nrst(i_nrst),
		.o_tick(tick)
	);

	noiseUnit i_noise (
		.clk(clk),
		.i_nrst(i_nrst),
		.i_tick(tick),
		.i_noiseShift(ctrl.shift),
		.i_noiseStep(ctrl.step),
		.o_noiseOut(noise)
	);

	noiseVolumeStage #(
		.MAX_CREDITS(MAX_CREDITS)
	) i_volume (
		.clk(clk),
		.i_nrst(i_nrst),
		.i_tick(tick),
		.i_enable(ctrl.enable),
		.i_noise(noise),
		.i_volLeft(volLeft),
		.i_volRight(volRight),
		.i_creditReturn(i_creditReturn),
		.o_frame(o_frame),
		.o_frameValid(o_frameValid),
		.o_overrun(o_overrun)
	);

endmodule

//--- test/tbSpuNoise.sv
`timescale 1ns/10ps

module tbSpuNoise;

	localparam int CLKS_PER_SAMPLE = 8;
	localparam int MAX_CREDITS = 2;
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int PLANNED_TICKS = 100;	// all tests together, with some room.
	localparam int WATCHDOG_NS = (PLANNED_TICKS * CLKS_PER_SAMPLE + 50) * CLK_PERIOD;
	localparam logic [15:0] UNITY = 16'h7fff;

	logic clk;
	logic i_nrst;
	spuBusPkg::regWrite_t i_regWr;
	logic i_creditReturn;
	spuAudioPkg::stereoFrame_t o_frame;
	logic o_frameValid;
	logic o_overrun;

	int seed = 32'hd9a7;
	int cycleCount = 0;
	int frameCount = 0;
	int firstFrameCycle = -1;
	int valueErrors = 0;
	int otherErrors = 0;
	int owedCredits = 0;	// frames taken but not yet paid back.
	int skippedFrames = 0;
	bit returnCredits = 1'b1;
	bit overrunAtLastFrame = 1'b0;

	// reference model state.
	logic [15:0] modelNoise = '0;
	logic modelEnable = 1'b0;
	logic [15:0] modelVolL = '0;
	logic [15:0] modelVolR = '0;

	spuNoiseTop #(
		.CLKS_PER_SAMPLE(CLKS_PER_SAMPLE),
		.MAX_CREDITS(MAX_CREDITS)
	) i_dut (
		.clk(clk),
		.i_nrst(i_nrst),
		.i_regWr(i_regWr),
		.i_creditReturn(i_creditReturn),
		.o_frame(o_frame),
		.o_frameValid(o_frameValid),
		.o_overrun(o_overrun)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// one step of the noise feedback, inverted parity into bit 0.
	function automatic logic [15:0] nextNoise(input logic [15:0] x);
		return {x[14:0], ~(x[15] ^ x[12] ^ x[11] ^ x[10])};
	endfunction

	// q15 volume scaling with floor rounding.
	function automatic logic [15:0] scaleSample(input logic [15:0] s, input logic [15:0] v);
		logic signed [31:0] prod;
		prod = $signed(s) * $signed(v);
		return 16'(prod >>> 15);
	endfunction

	function automatic spuAudioPkg::stereoFrame_t expectFrame(input logic [15:0] noiseVal);
		spuAudioPkg::stereoFrame_t f;
		f.left = modelEnable ? scaleSample(noiseVal, modelVolL) : '0;
		f.right = modelEnable ? scaleSample(noiseVal, modelVolR) : '0;
		return f;
	endfunction

	task automatic checkFrame();
		logic [15:0] cand;
		spuAudioPkg::stereoFrame_t expFrame;
		int steps;
		cand = nextNoise(modelNoise);
		if (o_overrun && !overrunAtLastFrame) begin
			// frames were dropped, find the one that got through.
			steps = 1;
			while (steps <= MAX_CREDITS + 1 && expectFrame(cand) != o_frame) begin
				cand = nextNoise(cand);
				steps++;
			end
			if (steps > MAX_CREDITS + 1) begin
				otherErrors++;
				$display("no noise value within %0d steps of the overrun matches the frame",
					MAX_CREDITS + 1);
				cand = nextNoise(modelNoise);
			end else begin
				skippedFrames += steps - 1;
			end
		end
		expFrame = expectFrame(cand);
		modelNoise = cand;
		overrunAtLastFrame = o_overrun;
		assert (o_frame.left == expFrame.left) else begin
			valueErrors++;
			$display("ERROR o_frame.left: got %h, expected %h (frame %0d)",
				o_frame.left, expFrame.left, frameCount);
		end
		assert (o_frame.right == expFrame.right) else begin
			valueErrors++;
			$display("ERROR o_frame.right: got %h, expected %h (frame %0d)",
				o_frame.right, expFrame.right, frameCount);
		end
	endtask

	// advance one clock, sample outputs and drive inputs just after the edge.
	task automatic stepCycle();
		@(posedge clk);
		#1;
		cycleCount++;
		if (o_frameValid) begin
			frameCount++;
			owedCredits++;
			if (frameCount == 1) begin
				firstFrameCycle = cycleCount;
			end
			checkFrame();
		end
		if (returnCredits && owedCredits > 0) begin
			i_creditReturn = 1'b1;
			owedCredits--;
		end else begin
			i_creditReturn = 1'b0;
		end
	endtask

	task automatic waitFrames(input int count);
		int target;
		target = frameCount + count;
		while (frameCount < target) begin
			stepCycle();
		end
	endtask

	task automatic writeReg(input spuBusPkg::regAddr_t addr, input logic [15:0] data);
		i_regWr.valid = 1'b1;
		i_regWr.addr = addr;
		i_regWr.data = data;
		stepCycle();
		i_regWr = '0;
		case (addr)
			spuBusPkg::REG_CTRL: modelEnable = data[8];
			spuBusPkg::REG_VOL_L: modelVolL = data;
			default: modelVolR = data;
		endcase
	endtask

	task automatic writeCtrl(input logic enable, input logic [3:0] shift, input logic [3:0] step);
		writeReg(spuBusPkg::REG_CTRL, {7'd0, enable, shift, step});
	endtask

	// quiet outputs up to and including the first tick cycle.
	assert property (@(posedge clk) disable iff (!i_nrst)
		(cycleCount <= RESET_CYCLES + CLKS_PER_SAMPLE) |-> (!o_frameValid && !o_overrun))
		else begin
			otherErrors++;
			$display("frame valid or overrun seen before the first sample tick");
		end

	assert property (@(posedge clk) disable iff (!i_nrst) o_overrun |=> o_overrun)
		else begin
			otherErrors++;
			$display("overrun flag dropped without a reset");
		end

	assert property (@(posedge clk) disable iff (!i_nrst)
		o_frameValid |-> (owedCredits <= MAX_CREDITS))
		else begin
			otherErrors++;
			$display("frame delivered with no credit left at the sink");
		end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the run did not finish in time");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		int releaseCycle;
		int withheldStart;
		int latency;
		clk = 1'b0;
		i_nrst = 1'b0;
		i_regWr = '0;
		i_creditReturn = 1'b0;
		repeat (RESET_CYCLES) begin
			stepCycle();
		end
		i_nrst = 1'b1;
		releaseCycle = cycleCount;

		// first frame and plain sequence at unity volume.
		writeCtrl(1'b1, 4'd0, 4'd1);
		writeReg(spuBusPkg::REG_VOL_L, UNITY);
		writeReg(spuBusPkg::REG_VOL_R, UNITY);
		waitFrames(1);
		latency = firstFrameCycle - releaseCycle;
		if (latency != CLKS_PER_SAMPLE + 1) begin
			otherErrors++;
			$display("first frame came %0d cycles after reset, expected %0d",
				latency, CLKS_PER_SAMPLE + 1);
		end
		waitFrames(19);

		// random volumes, new pair before every tick.
		repeat (16) begin
			writeReg(spuBusPkg::REG_VOL_L, 16'($random(seed)));
			writeReg(spuBusPkg::REG_VOL_R, 16'($random(seed)));
			waitFrames(1);
		end

		writeReg(spuBusPkg::REG_VOL_L, UNITY);
		writeReg(spuBusPkg::REG_VOL_R, UNITY);
		writeCtrl(1'b0, 4'd0, 4'd1);	// muted, noise keeps running.
		waitFrames(6);
		writeCtrl(1'b1, 4'd0, 4'd1);
		waitFrames(6);

		// hold back credits until a frame gets dropped.
		returnCredits = 1'b0;
		withheldStart = frameCount;
		while (!o_overrun) begin
			stepCycle();
		end
		if (frameCount - withheldStart > MAX_CREDITS) begin
			otherErrors++;
			$display("%0d frames delivered while only %0d credits were held",
				frameCount - withheldStart, MAX_CREDITS);
		end
		returnCredits = 1'b1;
		waitFrames(8);
		if (skippedFrames == 0) begin
			otherErrors++;
			$display("sequence did not skip ahead after the overrun");
		end
		assert (o_overrun == 1'b1) else begin
			valueErrors++;
			$display("ERROR o_overrun: got %h, expected %h", o_overrun, 1'b1);
		end

		// timer settings must not touch the shift register sequence.
		writeCtrl(1'b1, 4'd15, 4'd7);
		waitFrames(6);
		writeCtrl(1'b1, 4'd4, 4'd8);
		waitFrames(6);
		writeCtrl(1'b1, 4'd9, 4'd15);
		waitFrames(6);
		writeCtrl(1'b1, 4'd0, 4'd0);
		waitFrames(6);

		$display("checked %0d frames, %0d value errors, %0d other errors",
			frameCount, valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- tb.f
logic/spuAudioPkg.sv
logic/spuBusPkg.sv
logic/spuRegisterBank.sv
logic/sampleTickGen.sv
logic/noiseUnit.sv
logic/noiseVolumeStage.sv
logic/spuNoiseTop.sv
test/tbSpuNoise.sv

//--- Makefile
SIM := obj_dir/VtbSpuNoise
SRCS := $(shell cat tb.f)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) tb.f
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module tbSpuNoise -f tb.f -o VtbSpuNoise

run: $(SIM)
	$(SIM) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
